// ==== project.f ====
hdl/lanzonesPkg.sv
hdl/busSequencer.sv
hdl/instrDecode.sv
hdl/aluExecute.sv
hdl/registerFile.sv
hdl/lanzonesCore.sv
test/memModel.sv
test/lanzonesTb.sv

// ==== test/lanzonesTb.sv ====
module lanzonesTb;
   timeunit 1ns;
   timeprecision 100ps;
   import lanzonesPkg::*;

   localparam int SEED           = 91;
   localparam int MEM_WORDS      = 256;
   localparam int TIMEOUT_CYCLES = 1000;

   logic  clk;
   logic  rstn;
   logic  LEn;
   logic  RVld;
   logic  RRdy;
   logic  RWEn;
   logic  Halt;
   word_t RData;
   word_t RAddr;
   word_t RWData;

   word_t image [MEM_WORDS];   // Program and data image that refRun also uses
   word_t refRegs [32];
   word_t expAddr [$];
   word_t expData [$];
   int    wp;
   int    checked;
   string testName;

   lanzonesCore i_dut (.*);

   memModel #(.WORDS(MEM_WORDS), .SEED(SEED)) i_mem (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stopWithError(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   function automatic word_t encI(opcode_t op, logic [2:0] f3, regAddr_t rd, regAddr_t rs1,
                                  logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t encR(logic [6:0] f7, logic [2:0] f3, regAddr_t rd, regAddr_t rs1,
                                  regAddr_t rs2);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic word_t encSw(regAddr_t base, regAddr_t src, logic [11:0] imm);
      return {imm[11:5], src, base, 3'b010, imm[4:0], OP_STORE};
   endfunction

   task automatic emit(input word_t w);
      image[wp] = w;
      wp++;
   endtask

   // Runs the program from startPc up to its halt and queues the expected stores
   function automatic void refRun(input word_t startPc, output word_t haltPc);
      word_t pc;
      word_t ins;
      word_t a;
      word_t b;
      word_t immI;
      word_t res;
      logic  wr;
      pc     = startPc;
      haltPc = startPc;
      for (int n = 0; n < MEM_WORDS; n++) begin
         ins  = image[pc % MEM_WORDS];
         a    = refRegs[ins[19:15]];
         b    = refRegs[ins[24:20]];
         immI = {{20{ins[31]}}, ins[31:20]};
         wr   = 1'b1;
         res  = '0;
         pc   = pc + 1;
         case (ins[6:0])
            OP_HALT: begin
               haltPc = pc;
               return;
            end
            OP_LUI: res = {ins[31:12], 12'h000};
            OP_REG: begin
               if (ins[31:25] == 7'b0100000 && ins[14:12] == 3'b000) res = a - b;
               else if (ins[31:25] == 7'b0 && ins[14:12] == 3'b001) res = a << b[4:0];
               else res = a + b;
            end
            OP_IMM: begin
               case (ins[14:12])
                  3'b000: res = a + immI;
                  3'b001: res = a << immI[4:0];
                  3'b101: begin
                     res = a >> immI[4:0];
                     if (ins[31:25] == 7'b0100000 && a[31]) begin
                        res = res | ~(32'hFFFF_FFFF >> immI[4:0]);   // Sign fill
                     end
                  end
                  3'b111: res = a & immI;
                  default: res = a | immI;   // ORI and unknown funct3
               endcase
            end
            OP_LOAD: res = image[(a + immI) % MEM_WORDS];
            OP_STORE: begin
               wr = 1'b0;
               a  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
               image[a % MEM_WORDS] = b;
               expAddr.push_back(a);
               expData.push_back(b);
            end
            default: wr = 1'b0;
         endcase
         if (wr && ins[11:7] != 5'd0) refRegs[ins[11:7]] = res;
      end
   endfunction

   task automatic buildImage();
      for (int i = 0; i < MEM_WORDS; i++) begin
         image[i] = 32'h5A00_0000 ^ (i * 32'h0001_0101);
      end
      image[240] = 32'h8000_0010;
      image[241] = 32'h0000_0123;
      image[242] = 32'hF0F0_1234;
      wp = 0;
      emit({20'h12345, 5'd1, OP_LUI});
      emit(encI(OP_IMM, 3'b000, 2, 0, 12'hFF9));   // x2 = -7
      emit(encI(OP_IMM, 3'b110, 3, 1, 12'h0F0));
      emit(encI(OP_IMM, 3'b111, 4, 2, 12'h7F3));
      emit(encR(7'h00, 3'b000, 5, 3, 2));
      emit(encR(7'h20, 3'b000, 6, 1, 3));
      emit(encI(OP_IMM, 3'b000, 8, 0, 12'd35));    // Shifts by 3 only
      emit(encR(7'h00, 3'b001, 7, 1, 8));
      emit(encI(OP_IMM, 3'b001, 9, 1, 12'h004));
      emit(encI(OP_IMM, 3'b101, 10, 2, 12'h008));
      emit(encI(OP_IMM, 3'b101, 11, 2, 12'h402));  // SRAI
      emit(encI(OP_IMM, 3'b000, 0, 0, 12'h063));   // Write to x0
      for (int r = 0; r < 12; r++) begin
         emit(encSw(0, r, 12'(200 + r)));
      end
      emit({25'h0, OP_HALT});
      emit(encI(OP_LOAD, 3'b010, 12, 0, 12'd240));
      emit(encI(OP_LOAD, 3'b010, 13, 0, 12'd241));
      emit(encR(7'h00, 3'b000, 14, 12, 13));
      emit(encR(7'h20, 3'b000, 15, 13, 12));
      emit(encI(OP_IMM, 3'b101, 16, 12, 12'h403));
      emit(encI(OP_IMM, 3'b000, 17, 0, 12'd240));
      emit(encI(OP_LOAD, 3'b010, 18, 17, 12'd2));
      emit(encSw(17, 14, 12'hFEC));   // Address 220 by negative offset
      emit(encSw(0, 15, 12'd221));
      emit(encSw(0, 16, 12'd222));
      emit(encI(OP_LOAD, 3'b010, 19, 0, 12'd220));
      emit(encSw(0, 19, 12'd223));
      emit(encSw(17, 18, 12'hFF3));
      emit({25'h0, OP_HALT});
      for (int i = 0; i < MEM_WORDS; i++) begin
         i_mem.mem[i] = image[i];
      end
   endtask

   task automatic runSegment(input string name, input word_t startPc, output word_t haltPc);
      int total;
      int n;
      testName = name;
      refRun(startPc, haltPc);
      total = checked + expAddr.size();
      @(posedge clk);
      LEn <= 1'b1;
      @(posedge clk);
      LEn <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!RRdy) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT_CYCLES) stopWithError({name, ": no fetch after the LEn pulse"});
      end
      assert (RAddr == startPc)
         else stopWithError($sformatf("Fail %s first fetch: expected %h, actual %h",
                                      name, startPc, RAddr));
      n = 0;
      while (checked < total) begin
         @(posedge clk);
         n++;
         if (n > TIMEOUT_CYCLES) stopWithError({name, ": expected stores did not all arrive"});
      end
      n = 0;
      @(negedge clk);
      while (!Halt) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT_CYCLES) stopWithError({name, ": Halt did not rise after the program"});
      end
      repeat (20) begin
         @(negedge clk);
         assert (Halt && !RRdy) else stopWithError({name, ": bus request while halted"});
      end
   endtask

   initial begin : compareStores
      word_t gotAddr;
      word_t gotData;
      word_t wantAddr;
      word_t wantData;
      forever begin
         @(negedge clk);
         if (i_mem.storeAddr.size() > 0) begin
            gotAddr = i_mem.storeAddr.pop_front();
            gotData = i_mem.storeData.pop_front();
            assert (expAddr.size() > 0)
               else stopWithError({testName, ": store that the reference never made"});
            wantAddr = expAddr.pop_front();
            wantData = expData.pop_front();
            assert (gotAddr == wantAddr)
               else stopWithError($sformatf("Fail %s store address: expected %h, actual %h",
                                            testName, wantAddr, gotAddr));
            assert (gotData == wantData)
               else stopWithError($sformatf("Fail %s store data: expected %h, actual %h",
                                            testName, wantData, gotData));
            checked++;
         end
      end
   end

   initial begin
      word_t haltPc;
      rstn     = 1'b0;
      LEn      = 1'b0;
      checked  = 0;
      testName = "reset";
      foreach (refRegs[i]) begin
         refRegs[i] = '0;
      end
      buildImage();
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      repeat (10) begin
         @(negedge clk);
         assert (Halt && !RRdy) else stopWithError("Core left halt without an LEn pulse");
      end
      runSegment("alu", 32'd0, haltPc);
      runSegment("loadstore", haltPc, haltPc);   // Resumes after the first halt
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== test/memModel.sv ====
module memModel #(
   parameter int WORDS = 256,
   parameter int SEED  = 91
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               RRdy,
   input  logic               RWEn,
   input  lanzonesPkg::word_t RAddr,
   input  lanzonesPkg::word_t RWData,
   output logic               RVld,
   output lanzonesPkg::word_t RData
);
   timeunit 1ns;
   timeprecision 100ps;
   import lanzonesPkg::*;

   word_t  mem [WORDS];
   word_t  storeAddr [$];   // Completed stores in order
   word_t  storeData [$];
   integer seed = SEED;
   logic   busy;
   int     delay;

   initial begin
      RVld  = 1'b0;
      RData = '0;
   end

   always @(posedge clk) begin
      if (!rstn) begin
         RVld  <= 1'b0;
         busy  <= 1'b0;
         delay <= 0;
      end
      else begin
         RVld <= 1'b0;
         if (RVld) begin
            busy <= 1'b0;   // Core moves on now, new address next cycle
         end
         else if (!busy && RRdy) begin
            busy  <= 1'b1;
            delay <= 1 + ($unsigned($random(seed)) % 4);
         end
         else if (busy) begin
            if (delay == 1) begin
               RVld <= 1'b1;
               if (RWEn) begin
                  mem[RAddr % WORDS] <= RWData;
                  storeAddr.push_back(RAddr);
                  storeData.push_back(RWData);
               end
               else begin
                  RData <= mem[RAddr % WORDS];
               end
            end
            delay <= delay - 1;
         end
      end
   end

endmodule

// ==== hdl/lanzonesCore.sv ====
module lanzonesCore (
   input  logic               clk,
   input  logic               rstn,
   input  logic               RVld,
   input  lanzonesPkg::word_t RData,
   input  logic               LEn,
   output lanzonesPkg::word_t RWData,
   output logic               RWEn,
   output logic               RRdy,
   output lanzonesPkg::word_t RAddr,
   output logic               Halt
);
   import lanzonesPkg::*;

   word_t         instr;
   decodedInstr_t dec;
   word_t         rs1Data;
   word_t         rs2Data;
   word_t         aluResult;
   logic          execWr;
   logic          loadWr;

   // Controller and all bus outputs
   busSequencer i_busSequencer (
      .clk       (clk),
      .rstn      (rstn),
      .RVld      (RVld),
      .RData     (RData),
      .LEn       (LEn),
      .dec       (dec),
      .aluResult (aluResult),
      .rs2Data   (rs2Data),
      .instr     (instr),
      .execWr    (execWr),
      .loadWr    (loadWr),
      .RRdy      (RRdy),
      .RAddr     (RAddr),
      .RWEn      (RWEn),
      .RWData    (RWData),
      .Halt      (Halt)
   );

   instrDecode i_instrDecode (
      .instr (instr),
      .dec   (dec)
   );

   aluExecute i_aluExecute (
      .dec       (dec),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .aluResult (aluResult)
   );

   registerFile i_registerFile (
      .clk       (clk),
      .rstn      (rstn),
      .dec       (dec),
      .execWr    (execWr),
      .loadWr    (loadWr),
      .aluResult (aluResult),
      .RData     (RData),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data)
   );

endmodule

// ==== hdl/registerFile.sv ====
module registerFile (
   input  logic                       clk,
   input  logic                       rstn,
   input  lanzonesPkg::decodedInstr_t dec,
   input  logic                       execWr,
   input  logic                       loadWr,
   input  lanzonesPkg::word_t         aluResult,
   input  lanzonesPkg::word_t         RData,
   output lanzonesPkg::word_t         rs1Data,
   output lanzonesPkg::word_t         rs2Data
);
   import lanzonesPkg::*;

   word_t     regs [NUM_REGS];
   regWrite_t wr;

   // Load data wins over the ALU path
   always_comb begin
      wr.en   = execWr | loadWr;
      wr.addr = dec.rd;
      wr.data = loadWr ? RData : aluResult;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end
      else if (wr.en && (wr.addr != '0)) begin
         regs[wr.addr] <= wr.data;
      end
   end

   // x0 reads as zero
   assign rs1Data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
   assign rs2Data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

// ==== hdl/aluExecute.sv ====
module aluExecute (
   input  lanzonesPkg::decodedInstr_t dec,
   input  lanzonesPkg::word_t         rs1Data,
   input  lanzonesPkg::word_t         rs2Data,
   output lanzonesPkg::word_t         aluResult
);
   import lanzonesPkg::*;

   logic [4:0] shamtReg;
   logic [4:0] shamtImm;
   word_t      sum;

   // Only the low 5 bits shift
   assign shamtReg = rs2Data[4:0];
   assign shamtImm = dec.imm[4:0];

   // Shared by ADDI and the load/store address
   assign sum = rs1Data + dec.imm;

   always_comb begin
      case (dec.op)
         ADD:     aluResult = rs1Data + rs2Data;
         SUB:     aluResult = rs1Data - rs2Data;
         SLL:     aluResult = rs1Data << shamtReg;
         ADDI:    aluResult = sum;
         ORI:     aluResult = rs1Data | dec.imm;
         ANDI:    aluResult = rs1Data & dec.imm;
         SLLI:    aluResult = rs1Data << shamtImm;
         SRLI:    aluResult = rs1Data >> shamtImm;
         SRAI:    aluResult = word_t'($signed(rs1Data) >>> shamtImm);
         LUI:     aluResult = dec.imm;   // Shifted up in decode
         MEMADDR: aluResult = sum;
         default: aluResult = '0;
      endcase
   end

endmodule

// ==== hdl/instrDecode.sv ====
module instrDecode (
   input  lanzonesPkg::word_t         instr,
   output lanzonesPkg::decodedInstr_t dec
);
   import lanzonesPkg::*;

   opcode_t    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      immI;
   word_t      immS;
   word_t      immU;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immU = {instr[31:12], 12'h000};

   always_comb begin
      // Register fields taken straight from the word
      dec.rd  = instr[11:7];
      dec.rs1 = instr[19:15];
      dec.rs2 = instr[24:20];
      dec.cls = NOP;
      dec.op  = NONE;
      dec.imm = immI;

      case (opcode)
         OP_IMM: begin
            dec.cls = ALU;
            case (funct3)
               3'b000: dec.op = ADDI;
               3'b001: dec.op = SLLI;
               3'b101: begin
                  if (funct7 == 7'b0100000) begin
                     dec.op = SRAI;
                  end
                  else begin
                     dec.op = SRLI;   // Any other funct7 shifts logically
                  end
               end
               3'b110: dec.op = ORI;
               3'b111: dec.op = ANDI;
               default: dec.op = ORI;
            endcase
         end

         OP_LUI: begin
            dec.cls = ALU;
            dec.op  = LUI;
            dec.imm = immU;
         end

         OP_REG: begin
            dec.cls = ALU;
            dec.op  = ADD;   // Unknown funct3/funct7 fall back to ADD
            if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
               dec.op = SUB;
            end
            else if ((funct7 == 7'b0000000) && (funct3 == 3'b001)) begin
               dec.op = SLL;
            end
         end

         OP_STORE: begin
            dec.cls = STORE;
            dec.op  = MEMADDR;
            dec.imm = immS;
         end

         // Every funct3 is treated as LW
         OP_LOAD: begin
            dec.cls = LOAD;
            dec.op  = MEMADDR;
         end

         OP_HALT: dec.cls = HALT;

         default: dec.cls = NOP;
      endcase
   end

endmodule

// ==== hdl/busSequencer.sv ====
module busSequencer (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic                       RVld,
   input  lanzonesPkg::word_t         RData,
   input  logic                       LEn,
   input  lanzonesPkg::decodedInstr_t dec,
   input  lanzonesPkg::word_t         aluResult,
   input  lanzonesPkg::word_t         rs2Data,
   output lanzonesPkg::word_t         instr,
   output logic                       execWr,
   output logic                       loadWr,
   output logic                       RRdy,
   output lanzonesPkg::word_t         RAddr,
   output logic                       RWEn,
   output lanzonesPkg::word_t         RWData,
   output logic                       Halt
);
   import lanzonesPkg::*;

   seqState_t state;
   word_t     pc;
   word_t     pcNext;
   logic      busDone;

   assign pcNext  = pc + 32'd1;
   assign busDone = RRdy & RVld;   // RVld only counts with a request open

   // Register file strobes
   assign execWr = (state == sExec) && (dec.cls == ALU);
   assign loadWr = (state == sLoad) && busDone;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= sHalted;
         pc     <= '0;
         Halt   <= 1'b1;
         RRdy   <= 1'b0;
         RAddr  <= '0;
         RWEn   <= 1'b0;
         RWData <= '0;
      end
      else begin
         case (state)
            sHalted: begin
               if (LEn) begin
                  state <= sFetch;
                  Halt  <= 1'b0;
                  RRdy  <= 1'b1;
                  RAddr <= pc;
               end
            end

            sFetch: begin
               if (busDone) begin
                  state <= sExec;
                  RRdy  <= 1'b0;
               end
            end

            // Single cycle, PC advances for every class
            sExec: begin
               pc <= pcNext;
               case (dec.cls)
                  HALT: begin
                     state <= sHalted;
                     Halt  <= 1'b1;
                  end
                  LOAD: begin
                     state <= sLoad;
                     RRdy  <= 1'b1;
                     RAddr <= aluResult;
                  end
                  STORE: begin
                     state  <= sStore;
                     RRdy   <= 1'b1;
                     RWEn   <= 1'b1;
                     RAddr  <= aluResult;
                     RWData <= rs2Data;
                  end
                  default: begin
                     state <= sFetch;
                     RRdy  <= 1'b1;
                     RAddr <= pcNext;
                  end
               endcase
            end

            sLoad: begin
               if (busDone) begin
                  state <= sFetch;   // RRdy stays up for the fetch
                  RAddr <= pc;
               end
            end

            sStore: begin
               if (busDone) begin
                  state  <= sFetch;
                  RWEn   <= 1'b0;
                  RWData <= '0;
                  RAddr  <= pc;
               end
            end

            default: begin
               state <= sHalted;
               Halt  <= 1'b1;
               RRdy  <= 1'b0;
            end
         endcase
      end
   end

   // Instruction register, held through sLoad/sStore
   always_ff @(posedge clk) begin
      if ((state == sFetch) && busDone) begin
         instr <= RData;
      end
   end

endmodule

// ==== hdl/lanzonesPkg.sv ====
package lanzonesPkg;

   typedef logic [31:0] word_t;    // Data, instruction and word address
   typedef logic [4:0]  regAddr_t;
   typedef logic [6:0]  opcode_t;

   localparam int NUM_REGS = 32;

   // Major opcodes
   localparam opcode_t OP_IMM   = 7'b0010011;
   localparam opcode_t OP_LUI   = 7'b0110111;
   localparam opcode_t OP_REG   = 7'b0110011;
   localparam opcode_t OP_STORE = 7'b0100011;
   localparam opcode_t OP_LOAD  = 7'b0000011;
   localparam opcode_t OP_HALT  = 7'b1111111;

   typedef enum logic [3:0] {
      ADD,
      SUB,
      SLL,
      ADDI,
      ORI,
      ANDI,
      SLLI,
      SRLI,
      SRAI,
      LUI,
      MEMADDR,   // rs1 + imm for LW/SW
      NONE
   } aluOp_t;

   typedef enum logic [2:0] {
      ALU,
      LOAD,
      STORE,
      HALT,
      NOP
   } instrClass_t;

   typedef enum logic [2:0] {
      sHalted,
      sFetch,
      sExec,
      sLoad,
      sStore
   } seqState_t;

   typedef struct packed {
      instrClass_t cls;
      aluOp_t      op;
      regAddr_t    rd;
      regAddr_t    rs1;
      regAddr_t    rs2;
      word_t       imm;   // Already extended
   } decodedInstr_t;

   typedef struct packed {
      logic     en;
      regAddr_t addr;
      word_t    data;
   } regWrite_t;

endpackage
